//--- hdl/ifu_pkg.sv
package ifu_pkg;

  localparam int XLEN = 32;

  // rv32 major opcodes that end sequential fetch.
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;
  localparam logic [XLEN-1:0] INST_NOP     = 32'h0000_0013;  // addi x0, x0, 0.

  // line refill sequence, one word per read.
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    REQ0  = 3'd1,
    WAIT0 = 3'd2,
    REQ1  = 3'd3,
    WAIT1 = 3'd4,
    DONE  = 3'd5
  } l1i_state_t;

endpackage

//--- hdl/ifu_fetch_ctrl.sv
`timescale 1ns/1ps

module ifu_fetch_ctrl import ifu_pkg::*; #(
  parameter logic [XLEN-1:0] PC_INIT = '0
) (
  input  logic            clk,
  input  logic            rst,

  input  logic            hit_i,
  input  logic [XLEN-1:0] hit_inst_i,
  output logic [XLEN-1:0] fetch_pc_o,
  output logic            flush_o,

  input  logic            next_ready_i,
  output logic [XLEN-1:0] inst_o,
  output logic [XLEN-1:0] pc_o,
  output logic            valid_o,

  input  logic            redirect_valid_i,
  input  logic [XLEN-1:0] redirect_pc_i
);

  logic [XLEN-1:0] pc_q;
  logic            stall_q;
  logic [6:0]      opcode;
  logic            stop_op;
  logic            fence_i;
  logic            xfer;

  assign opcode = hit_inst_i[6:0];

  // next pc unknown until the core resolves it.
  assign stop_op = (opcode == OP_JAL) ||
                   (opcode == OP_JALR) ||
                   (opcode == OP_BRANCH) ||
                   (opcode == OP_SYSTEM) ||
                   (opcode == OP_LOAD);

  assign fence_i = (hit_inst_i == INST_FENCE_I);

  assign valid_o = hit_i && !stall_q;
  assign xfer    = valid_o && next_ready_i;
  assign flush_o = xfer && fence_i;  // clears the cache on the pc step.

  assign fetch_pc_o = pc_q;
  assign pc_o       = pc_q;
  assign inst_o     = hit_inst_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= PC_INIT;
      stall_q <= 1'b0;
    end else if (stall_q) begin
      if (redirect_valid_i) begin
        pc_q    <= redirect_pc_i;
        stall_q <= 1'b0;
      end
    end else if (xfer) begin
      if (stop_op) begin
        stall_q <= 1'b1;  // pc held until redirect.
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // decode sees a steady word while it holds off.
  a_hold_under_backpressure: assert property (
    @(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> (valid_o && $stable(inst_o))
  ) else $error("fetch output dropped or changed while decode held it off");

endmodule

//--- hdl/l1i_cache.sv
`timescale 1ns/1ps

module l1i_cache import ifu_pkg::*; #(
  parameter int L1I_SETS  = 4,
  parameter int MEM_DEPTH = 256
) (
  input  logic                         clk,
  input  logic                         rst,

  input  logic [XLEN-1:0]              fetch_pc_i,
  input  logic                         flush_i,
  output logic                         hit_o,
  output logic [XLEN-1:0]              hit_inst_o,

  output logic [$clog2(MEM_DEPTH)-1:0] mem_araddr_o,
  output logic                         mem_arvalid_o,
  input  logic [XLEN-1:0]              mem_rdata_i,
  input  logic                         mem_rvalid_i
);

  localparam int AW    = $clog2(MEM_DEPTH);  // word address bits.
  localparam int IDX_W = $clog2(L1I_SETS);
  localparam int TAG_W = AW - 1 - IDX_W;     // two words per line.

  l1i_state_t state_q;

  logic [XLEN-1:0]  data_q [L1I_SETS][2];
  logic [TAG_W-1:0] tag_q [L1I_SETS];
  logic [L1I_SETS-1:0] valid_q;

  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic             pc_off;
  logic             line_hit;

  logic [AW-2:0]    fill_line_q;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic             fill_word;

  // byte pc split into tag, set and word within line.
  assign pc_off = fetch_pc_i[2];
  assign pc_idx = fetch_pc_i[IDX_W+2:3];
  assign pc_tag = fetch_pc_i[AW+1:IDX_W+3];

  assign line_hit = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

  assign hit_o      = line_hit && (state_q == IDLE);
  assign hit_inst_o = data_q[pc_idx][pc_off];

  assign fill_idx  = fill_line_q[IDX_W-1:0];
  assign fill_tag  = fill_line_q[AW-2:IDX_W];
  assign fill_word = (state_q == REQ1) || (state_q == WAIT1);

  assign mem_araddr_o  = {fill_line_q, fill_word};
  assign mem_arvalid_o = (state_q == REQ0) || (state_q == WAIT0) ||
                         (state_q == REQ1) || (state_q == WAIT1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;  // fence.i.
      end
      case (state_q)
        IDLE: begin
          if (!line_hit) begin
            state_q <= REQ0;
          end
        end
        REQ0: begin
          state_q <= WAIT0;
        end
        WAIT0: begin
          if (mem_rvalid_i) begin
            state_q <= REQ1;
          end
        end
        REQ1: begin
          state_q <= WAIT1;
        end
        WAIT1: begin
          if (mem_rvalid_i) begin
            state_q           <= DONE;
            valid_q[fill_idx] <= 1'b1;  // line complete.
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      fill_line_q <= fetch_pc_i[AW+1:3];  // latched when the miss is seen.
    end
    if (mem_rvalid_i && (state_q == WAIT0)) begin
      data_q[fill_idx][0] <= mem_rdata_i;
    end
    if (mem_rvalid_i && (state_q == WAIT1)) begin
      data_q[fill_idx][1] <= mem_rdata_i;
      tag_q[fill_idx]     <= fill_tag;
    end
  end

  // data is only taken while a read waits for it.
  a_rvalid_in_wait: assert property (
    @(posedge clk) disable iff (rst)
    mem_rvalid_i |-> ((state_q == WAIT0) || (state_q == WAIT1))
  ) else $error("read data arrived while no refill read was waiting");

  // the fetch pc must not move while its line is refilled.
  a_fill_hits: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == DONE) |=> hit_o
  ) else $error("refilled line does not hit, state %s", state_q.name());

endmodule

//--- hdl/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import ifu_pkg::*; #(
  parameter int MEM_DEPTH   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  logic                         clk,
  input  logic                         rst,

  input  logic [$clog2(MEM_DEPTH)-1:0] araddr_i,
  input  logic                         arvalid_i,
  output logic [XLEN-1:0]              rdata_o,
  output logic                         rvalid_o,

  input  logic                         load_we_i,
  input  logic [$clog2(MEM_DEPTH)-1:0] load_addr_i,
  input  logic [XLEN-1:0]              load_data_i
);

  localparam int AW = $clog2(MEM_DEPTH);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  logic [XLEN-1:0] mem_q [MEM_DEPTH];
  logic            busy_q;
  logic [CW-1:0]   cnt_q;
  logic [AW-1:0]   addr_q;
  logic            start;
  logic            fire;
  logic [AW-1:0]   rd_addr;

  // request stays up through its data cycle, so skip that one.
  assign start   = arvalid_i && !busy_q && !rvalid_o;
  assign fire    = busy_q ? (cnt_q == CW'(1)) : (start && (MEM_LATENCY == 1));
  assign rd_addr = busy_q ? addr_q : araddr_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= fire;
      if (fire) begin
        busy_q <= 1'b0;
      end else if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= CW'(MEM_LATENCY - 1);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
    if (start) begin
      addr_q <= araddr_i;
    end
    if (fire) begin
      rdata_o <= mem_q[rd_addr];
    end
  end

  a_rvalid_answers: assert property (
    @(posedge clk) disable iff (rst)
    rvalid_o |-> (arvalid_i && $past(arvalid_i, MEM_LATENCY))
  ) else $error("read data returned with no request pending");

endmodule

//--- hdl/ifu_top.sv
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*; #(
  parameter int              L1I_SETS    = 4,
  parameter int              MEM_DEPTH   = 256,
  parameter int              MEM_LATENCY = 3,
  parameter logic [XLEN-1:0] PC_INIT     = '0
) (
  input  logic                         clk,
  input  logic                         rst,

  output logic [XLEN-1:0]              inst_o,
  output logic [XLEN-1:0]              pc_o,
  output logic                         valid_o,
  input  logic                         next_ready_i,

  input  logic                         redirect_valid_i,
  input  logic [XLEN-1:0]              redirect_pc_i,

  input  logic                         load_we_i,
  input  logic [$clog2(MEM_DEPTH)-1:0] load_addr_i,
  input  logic [XLEN-1:0]              load_data_i
);

  logic [XLEN-1:0]              fetch_pc;
  logic                         flush;
  logic                         hit;
  logic [XLEN-1:0]              hit_inst;
  logic [$clog2(MEM_DEPTH)-1:0] mem_araddr;
  logic                         mem_arvalid;
  logic [XLEN-1:0]              mem_rdata;
  logic                         mem_rvalid;

  ifu_fetch_ctrl #(
    .PC_INIT (PC_INIT)
  ) u_fetch_ctrl (
    .clk              (clk),
    .rst              (rst),
    .hit_i            (hit),
    .hit_inst_i       (hit_inst),
    .fetch_pc_o       (fetch_pc),
    .flush_o          (flush),
    .next_ready_i     (next_ready_i),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .valid_o          (valid_o),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  l1i_cache #(
    .L1I_SETS  (L1I_SETS),
    .MEM_DEPTH (MEM_DEPTH)
  ) u_l1i_cache (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc_i    (fetch_pc),
    .flush_i       (flush),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .mem_araddr_o  (mem_araddr),
    .mem_arvalid_o (mem_arvalid),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid)
  );

  inst_mem #(
    .MEM_DEPTH   (MEM_DEPTH),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_inst_mem (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (mem_araddr),
    .arvalid_i   (mem_arvalid),
    .rdata_o     (mem_rdata),
    .rvalid_o    (mem_rvalid),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

//--- verif/ifu_tb.sv
`timescale 1ns/1ps

module ifu_tb import ifu_pkg::*; ();

  localparam int MEM_DEPTH   = 256;
  localparam int AW          = $clog2(MEM_DEPTH);
  localparam int MEM_LATENCY = 3;
  localparam int MISS_CYC    = 2 * (MEM_LATENCY + 1) + 2;
  localparam int N_INST      = 40 + 40 + 5 + 6 + 6 + 200;  // transfers over all tests.
  localparam logic [XLEN-1:0] PC_INIT = '0;

  logic            clk = 1'b0;
  logic            rst;
  logic [XLEN-1:0] inst_o;
  logic [XLEN-1:0] pc_o;
  logic            valid_o;
  logic            next_ready_i;
  logic            redirect_valid_i;
  logic [XLEN-1:0] redirect_pc_i;
  logic            load_we_i;
  logic [AW-1:0]   load_addr_i;
  logic [XLEN-1:0] load_data_i;

  logic [XLEN-1:0] shadow [MEM_DEPTH];
  logic [XLEN-1:0] exp_pc;
  logic            exp_stall;
  logic            hold_chk;
  logic [XLEN-1:0] held_pc;
  logic [XLEN-1:0] held_inst;
  logic [15:0]     lfsr_q;
  string           test_name;
  int              n_xfer = 0;
  int              err_count = 0;
  int              err_at_start = 0;
  int              pass_count = 0;
  int              fail_count = 0;

  always #2 clk = ~clk;

  ifu_top dut (
    .clk              (clk),
    .rst              (rst),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .valid_o          (valid_o),
    .next_ready_i     (next_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .load_we_i        (load_we_i),
    .load_addr_i      (load_addr_i),
    .load_data_i      (load_data_i)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [XLEN-1:0] mk_addi(input logic [7:0] w);
    return {4'h0, w, 5'd0, 3'b000, 5'd2, 7'b0010011};  // addi x2, x0, w.
  endfunction

  function automatic logic [XLEN-1:0] mk_op(input logic [6:0] op, input logic [7:0] w);
    return {4'h0, w, 13'd0, op};
  endfunction

  // word at pc, and the pc that follows it once it is taken by decode.
  function automatic logic [XLEN-1:0] ref_next(input logic [XLEN-1:0] pc,
                                               output logic [XLEN-1:0] inst,
                                               output logic stop);
    logic [6:0] op;
    inst = shadow[pc[AW+1:2]];
    op   = inst[6:0];
    stop = (op == OP_JAL) || (op == OP_JALR) || (op == OP_BRANCH) ||
           (op == OP_SYSTEM) || (op == OP_LOAD);
    return stop ? pc : pc + 32'd4;  // stop waits for the redirect.
  endfunction

  task automatic draw(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  always @(posedge clk) begin : compare
    logic [XLEN-1:0] exp_inst;
    logic [XLEN-1:0] next_pc;
    logic            stop;
    if (!rst) begin
      if (hold_chk && (!valid_o || pc_o !== held_pc || inst_o !== held_inst)) begin
        $display("%s: fetch output changed while ready was low, pc %h", test_name, pc_o);
        err_count++;
      end
      if (valid_o && exp_stall) begin
        $display("%s: valid_o high while waiting for a redirect, pc %h", test_name, pc_o);
        err_count++;
      end
      if (valid_o && next_ready_i) begin
        next_pc = ref_next(exp_pc, exp_inst, stop);
        if (pc_o !== exp_pc) begin
          $display("mismatch %s pc expected %h actual %h", test_name, exp_pc, pc_o);
          err_count++;
        end
        if (inst_o !== exp_inst) begin
          $display("mismatch %s inst expected %h actual %h", test_name, exp_inst, inst_o);
          err_count++;
        end
        exp_pc    = next_pc;
        exp_stall = stop;
        n_xfer++;
      end else if (exp_stall && redirect_valid_i) begin
        exp_pc    = redirect_pc_i;
        exp_stall = 1'b0;
      end
      hold_chk  = valid_o && !next_ready_i;
      held_pc   = pc_o;
      held_inst = inst_o;
    end
  end

  task automatic build_program();
    for (int w = 0; w < MEM_DEPTH; w++) begin
      shadow[w] = (w % 4 == 3) ? mk_op(OP_JAL, 8'(w)) : mk_addi(8'(w));
    end
    for (int w = 0; w < 80; w++) begin
      shadow[w] = mk_addi(8'(w));
    end
    shadow[80]  = mk_op(OP_BRANCH, 8'd80);
    shadow[84]  = mk_op(OP_JAL, 8'd84);
    shadow[88]  = mk_op(OP_JALR, 8'd88);
    shadow[92]  = mk_op(OP_SYSTEM, 8'd92);
    shadow[96]  = mk_op(OP_LOAD, 8'd96);
    shadow[100] = mk_addi(8'd100);
    shadow[101] = mk_op(OP_JAL, 8'd101);
    shadow[120] = mk_addi(8'd120);
    shadow[121] = mk_op(OP_JAL, 8'd121);
    shadow[122] = INST_FENCE_I;
    shadow[123] = mk_op(OP_JAL, 8'd123);
  endtask

  // one word a cycle, far ahead of the refills.
  task automatic load_program();
    for (int w = 0; w < MEM_DEPTH; w++) begin
      @(negedge clk);
      load_we_i   = 1'b1;
      load_addr_i = AW'(w);
      load_data_i = shadow[w];
    end
    @(negedge clk);
    load_we_i = 1'b0;
  endtask

  task automatic write_word(input logic [AW-1:0] addr, input logic [XLEN-1:0] data);
    @(negedge clk);
    load_we_i    = 1'b1;
    load_addr_i  = addr;
    load_data_i  = data;
    shadow[addr] = data;
    @(negedge clk);
    load_we_i = 1'b0;
  endtask

  task automatic step(input bit rnd);
    logic [31:0] r;
    @(negedge clk);
    redirect_valid_i = 1'b0;
    if (rnd) begin
      draw(2, r);
      next_ready_i = |r[1:0];
    end else begin
      next_ready_i = 1'b1;
    end
  endtask

  task automatic run_xfers(input int n, input bit rnd);
    int goal;
    goal = n_xfer + n;
    while (n_xfer < goal) begin
      step(rnd);
    end
  endtask

  task automatic wait_stall();
    while (!exp_stall) begin
      step(1'b0);
    end
  endtask

  task automatic redirect_after_hold(input logic [XLEN-1:0] target, input bit check_hit);
    logic [31:0] hold;
    wait_stall();
    draw(3, hold);
    repeat (hold) step(1'b0);
    @(negedge clk);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    step(1'b0);
    if (check_hit && !valid_o) begin
      $display("%s: valid_o low one cycle after redirect to cached pc %h", test_name, target);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_count;
  endtask

  task automatic end_test();
    if (err_count == err_at_start) begin
      $display("test %s ok", test_name);
      pass_count++;
    end else begin
      $display("test %s failed with %0d errors", test_name, err_count - err_at_start);
      fail_count++;
    end
  endtask

  initial begin : stimulus
    int          goal;
    logic [31:0] hold;
    logic [31:0] tgt;
    rst              = 1'b1;
    next_ready_i     = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    load_we_i        = 1'b0;
    load_addr_i      = '0;
    load_data_i      = '0;
    lfsr_q           = 16'd49232;
    exp_pc           = PC_INIT;
    exp_stall        = 1'b0;
    hold_chk         = 1'b0;
    build_program();
    fork
      load_program();
    join_none
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst          = 1'b0;
    next_ready_i = 1'b1;

    start_test("reset_seq");
    run_xfers(40, 1'b0);
    end_test();

    start_test("backpressure");
    run_xfers(40, 1'b1);
    end_test();

    start_test("ctrl_stall");
    for (int k = 1; k <= 5; k++) begin
      redirect_after_hold(32'((80 + 4 * k) * 4), 1'b0);  // next stop op, then word 100.
    end
    end_test();

    start_test("redirect_hit");
    redirect_after_hold(32'd400, 1'b1);
    redirect_after_hold(32'd400, 1'b1);
    redirect_after_hold(32'd480, 1'b0);
    end_test();

    start_test("fence_i");
    wait_stall();  // words 120 and 121 now cached.
    write_word(AW'(120), INST_NOP);
    redirect_after_hold(32'd488, 1'b0);
    redirect_after_hold(32'd480, 1'b0);
    wait_stall();
    end_test();

    start_test("random_mix");
    goal = n_xfer + 200;
    draw(3, hold);
    while (n_xfer < goal) begin
      step(1'b1);
      if (exp_stall) begin
        if (hold == 0) begin
          draw(8, tgt);
          redirect_valid_i = 1'b1;
          redirect_pc_i    = {22'd0, tgt[7:0], 2'b00};
          draw(3, hold);
        end else begin
          hold--;
        end
      end
    end
    end_test();

    $display("tests ok %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #((16 + N_INST * MISS_CYC * 2) * 4);
    $display("timeout: fetch stopped making progress at pc %h after %0d transfers",
             exp_pc, n_xfer);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- build.f
hdl/ifu_pkg.sv
hdl/ifu_fetch_ctrl.sv
hdl/l1i_cache.sv
hdl/inst_mem.sv
hdl/ifu_top.sv
verif/ifu_tb.sv
